// ==== Bender.yml ====
package:
  name: uart_tx_hub

export_include_dirs:
  - include

sources:
  - files:
      - hdl/uart_pkg.sv
      - hdl/uart_tx.sv
      - hdl/tx_channel_fifo.sv
      - hdl/tx_arbiter.sv
      - hdl/uart_tx_hub.sv
  - target: test
    files:
      - test/uart_tx_hub_sva.sv
      - test/tb_uart_tx_hub.sv

// ==== hdl/tx_arbiter.sv ====
// round-robin transmit arbiter
// picks a non-empty channel FIFO, pops it and starts the transmitter

`timescale 1ns/1ps
`default_nettype none

module tx_arbiter
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       ch0_empty,
  input  uart_byte_t ch0_head,
  input  logic       ch1_empty,
  input  uart_byte_t ch1_head,
  input  logic       busy,
  output logic       ch0_pop,
  output logic       ch1_pop,
  output logic       start,
  output uart_byte_t tx_data
);

  chan_sel_t last_win;  // channel served most recently
  chan_sel_t sel;
  logic      start_q;   // start went out last cycle
  logic      issue;

  // busy only rises on the edge that samples start, so skip that cycle too
  assign issue = !busy && !start_q && (!ch0_empty || !ch1_empty);

  always_comb begin
    if (!ch0_empty && !ch1_empty) begin
      sel = ~last_win;  // both waiting, alternate
    end else if (ch0_empty) begin
      sel = 1'b1;
    end else begin
      sel = 1'b0;
    end
  end

  assign ch0_pop = issue && (sel == 1'b0);
  assign ch1_pop = issue && (sel == 1'b1);
  assign start   = issue;
  assign tx_data = (sel == 1'b1) ? ch1_head : ch0_head;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_win <= 1'b1;  // channel 0 first
      start_q  <= 1'b0;
    end else begin
      start_q <= issue;
      if (issue) begin
        last_win <= sel;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/tx_channel_fifo.sv ====
// per-channel transmit FIFO
// buffers source bytes and hands one credit back for each byte popped

`timescale 1ns/1ps
`default_nettype none

`include "uart_macros.svh"

module tx_channel_fifo
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       wr_valid,  // never arrives when full, the source holds no credit then
  input  uart_byte_t wr_data,
  input  logic       pop,
  output uart_byte_t rd_data,   // head byte, valid while not empty
  output logic       empty,
  output logic       credit
);

  localparam int IDX_W = $clog2(`UART_FIFO_DEPTH);

  uart_byte_t mem [`UART_FIFO_DEPTH];
  fifo_ptr_t  wr_ptr;
  fifo_ptr_t  rd_ptr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      credit <= 1'b0;
    end else begin
      if (wr_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      credit <= pop;  // one credit back per byte released
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_ptr[IDX_W-1:0]] <= wr_data;
    end
  end

  assign rd_data = mem[rd_ptr[IDX_W-1:0]];

  // equal pointers including the wrap bit mean nothing stored
  assign empty = (wr_ptr == rd_ptr);

endmodule

`default_nettype wire

// ==== hdl/uart_pkg.sv ====
// uart tx hub types
// payload, counter, pointer and channel widths plus the transmitter states

`default_nettype none

`include "uart_macros.svh"

package uart_pkg;

  typedef logic [7:0] uart_byte_t;  // one payload byte

  // cycle count inside one bit, at least one bit wide
  typedef logic [((`UART_BIT_TIME > 1) ? $clog2(`UART_BIT_TIME) : 1)-1:0] bit_timer_t;

  typedef logic [3:0] bit_idx_t;  // must reach 8

  // index bits plus one wrap bit
  typedef logic [$clog2(`UART_FIFO_DEPTH):0] fifo_ptr_t;

  typedef logic [0:0] chan_sel_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

endpackage

`default_nettype wire

// ==== hdl/uart_tx.sv ====
// uart transmitter
// sends one 8N1 frame per start pulse, lsb first, UART_BIT_TIME cycles per bit

`timescale 1ns/1ps
`default_nettype none

`include "uart_macros.svh"

module uart_tx
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,    // one-cycle request, only while busy is low
  input  uart_byte_t tx_data,  // captured with start
  output logic       tx,
  output logic       busy
);

  localparam bit_timer_t BIT_LAST = bit_timer_t'(`UART_BIT_TIME - 1);

  tx_state_e  state;
  bit_timer_t bit_timer;
  bit_idx_t   bit_idx;
  uart_byte_t data_q;  // frame payload, held for the whole frame

  // the first cycle of every bit is the one in which the fsm changes state,
  // so the timer is reloaded with one less than the bit time
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= TX_IDLE;
      bit_timer <= '0;
      bit_idx   <= '0;
      tx        <= 1'b1;
      busy      <= 1'b0;
    end else begin
      unique case (state)
        TX_IDLE: begin
          if (start) begin
            busy      <= 1'b1;
            tx        <= 1'b0;  // start bit
            bit_timer <= BIT_LAST;
            state     <= TX_START;
          end
        end

        TX_START: begin
          bit_timer <= bit_timer - 1'b1;
          if (bit_timer == '0) begin
            tx        <= data_q[0];
            bit_idx   <= 4'd1;  // bit 0 goes out now
            bit_timer <= BIT_LAST;
            state     <= TX_DATA;
          end
        end

        TX_DATA: begin
          bit_timer <= bit_timer - 1'b1;
          if (bit_timer == '0) begin
            bit_timer <= BIT_LAST;
            if (bit_idx == 4'd8) begin
              bit_idx <= '0;
              tx      <= 1'b1;  // stop bit
              state   <= TX_STOP;
            end else begin
              tx      <= data_q[bit_idx[2:0]];
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end

        TX_STOP: begin
          bit_timer <= bit_timer - 1'b1;
          if (bit_timer == '0) begin
            busy  <= 1'b0;
            state <= TX_IDLE;
          end
        end

        default: state <= TX_IDLE;
      endcase
    end
  end

  // payload register, loaded only when a frame begins
  always_ff @(posedge clk) begin
    if (state == TX_IDLE && start) begin
      data_q <= tx_data;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/uart_tx_hub.sv ====
// two-channel uart transmit hub
// credit flow-controlled byte FIFOs sharing one 8N1 transmitter

`timescale 1ns/1ps
`default_nettype none

module uart_tx_hub (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       ch0_valid,
  input  logic [7:0] ch0_data,
  output logic       ch0_credit,
  input  logic       ch1_valid,
  input  logic [7:0] ch1_data,
  output logic       ch1_credit,
  output logic       tx,
  output logic       busy
);

  logic       ch0_empty;
  logic       ch1_empty;
  logic [7:0] ch0_head;
  logic [7:0] ch1_head;
  logic       ch0_pop;
  logic       ch1_pop;
  logic       start;
  logic [7:0] tx_data;

  tx_channel_fifo u_fifo0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_valid (ch0_valid),
    .wr_data  (ch0_data),
    .pop      (ch0_pop),
    .rd_data  (ch0_head),
    .empty    (ch0_empty),
    .credit   (ch0_credit)
  );

  tx_channel_fifo u_fifo1 (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_valid (ch1_valid),
    .wr_data  (ch1_data),
    .pop      (ch1_pop),
    .rd_data  (ch1_head),
    .empty    (ch1_empty),
    .credit   (ch1_credit)
  );

  tx_arbiter u_arb (
    .clk       (clk),
    .rst_n     (rst_n),
    .ch0_empty (ch0_empty),
    .ch0_head  (ch0_head),
    .ch1_empty (ch1_empty),
    .ch1_head  (ch1_head),
    .busy      (busy),
    .ch0_pop   (ch0_pop),
    .ch1_pop   (ch1_pop),
    .start     (start),
    .tx_data   (tx_data)
  );

  uart_tx u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .tx_data (tx_data),
    .tx      (tx),
    .busy    (busy)
  );

endmodule

`default_nettype wire

// ==== include/uart_macros.svh ====
// uart tx hub settings
// clock, baud and per-channel FIFO depth shared by the hub and its testbench

`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// system clock in hertz
`define UART_CLK_HZ 8_000_000

// serial line rate
`define UART_BAUD 1_000_000

// clock cycles spent on each serial bit
`define UART_BIT_TIME (`UART_CLK_HZ / `UART_BAUD)

// bytes per channel FIFO, also the initial credit of each source (power of two)
`define UART_FIFO_DEPTH 4

`endif

// ==== test/tb_uart_tx_hub.sv ====
// testbench for the two-channel uart transmit hub
// credit-tracking sources, a serial line decoder and directed tests

`timescale 1ns/1ps
`default_nettype none

`include "uart_macros.svh"

module tb_uart_tx_hub;

  localparam int BIT_TIME    = `UART_BIT_TIME;
  localparam int DEPTH       = `UART_FIFO_DEPTH;
  localparam int FRAME_CYC   = 10 * BIT_TIME;
  localparam int TIMEOUT_CYC = 3000;  // 18 frames of about 81 cycles, reset and idle gaps

  logic       clk;
  logic       rst_n;
  logic       ch0_valid;
  logic [7:0] ch0_data;
  logic       ch0_credit;
  logic       ch1_valid;
  logic [7:0] ch1_data;
  logic       ch1_credit;
  logic       tx;
  logic       busy;

  int         cyc;
  int         errors;
  int         checks;
  int         seed;
  int         valid_cyc;       // cycle of the most recent valid drive
  int         sent [2];
  int         returned [2];
  logic [7:0] rx_q [$];        // bytes seen on the line
  int         start_cyc_q [$];

  uart_tx_hub dut (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYC) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // credit pulses are registered, so count them on the rising edge
  always @(posedge clk) begin
    if (rst_n && ch0_credit) returned[0]++;
    if (rst_n && ch1_credit) returned[1]++;
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  // line decoder, samples every bit near its middle
  initial begin : decoder
    logic [7:0] rx_byte;
    forever begin
      @(negedge clk);
      if (rst_n && tx === 1'b0) begin
        start_cyc_q.push_back(cyc);
        repeat (BIT_TIME / 2) @(negedge clk);
        check_value(tx, 1'b0, "start bit at mid-bit");
        for (int k = 0; k < 8; k++) begin
          repeat (BIT_TIME) @(negedge clk);
          rx_byte[k] = tx;  // lsb first
        end
        repeat (BIT_TIME) @(negedge clk);
        check_value(tx, 1'b1, "stop bit");
        rx_q.push_back(rx_byte);
      end
    end
  end

  // called on a falling edge, waits for a credit, returns one cycle later
  task automatic send_byte(input int ch, input logic [7:0] data);
    while (sent[ch] - returned[ch] >= DEPTH) begin
      @(negedge clk);
    end
    if (ch == 0) begin
      ch0_valid = 1'b1;
      ch0_data  = data;
    end else begin
      ch1_valid = 1'b1;
      ch1_data  = data;
    end
    sent[ch]++;
    check_value(returned[ch] <= sent[ch], 1, "credit returned only for bytes sent");
    valid_cyc = cyc;
    @(negedge clk);
    ch0_valid = 1'b0;
    ch1_valid = 1'b0;
  endtask

  task automatic wait_bytes(input int n);
    while (rx_q.size() < n) begin
      @(negedge clk);
    end
  endtask

  // every credit back and the line quiet
  task automatic wait_idle();
    while (busy || sent[0] != returned[0] || sent[1] != returned[1]) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
  endtask

  task automatic idle_after_reset();
    repeat (20) begin
      @(negedge clk);
      check_value(tx, 1'b1, "tx idle after reset");
      check_value(busy, 1'b0, "busy after reset");
    end
    check_value(returned[0] + returned[1], 0, "credit pulses after reset");
  endtask

  task automatic single_byte_latency();
    logic [7:0] b;
    int         r0;
    int         busy_cyc;
    b = 8'($random(seed));
    r0 = returned[0];
    busy_cyc = 0;
    rx_q.delete();
    start_cyc_q.delete();
    send_byte(0, b);
    while (!busy) begin
      @(negedge clk);
    end
    while (busy) begin
      busy_cyc++;
      @(negedge clk);
    end
    wait_bytes(1);
    check_value(rx_q[0], b, "channel 0 single byte");
    // one cycle for the FIFO write, one for arbitration
    check_value(start_cyc_q[0] - valid_cyc, 2, "valid to start bit latency");
    check_value(busy_cyc, FRAME_CYC, "busy length");
    wait_idle();
    check_value(returned[0] - r0, 1, "channel 0 credit pulses");
  endtask

  task automatic credit_refill_ch1();
    logic [7:0] exp [$];
    logic [7:0] b;
    int         r1;
    r1 = returned[1];
    rx_q.delete();
    for (int i = 0; i < DEPTH + 2; i++) begin
      b = 8'($random(seed));
      exp.push_back(b);
      send_byte(1, b);
    end
    wait_bytes(DEPTH + 2);
    for (int i = 0; i < DEPTH + 2; i++) check_value(rx_q[i], exp[i], "channel 1 byte order");
    wait_idle();
    check_value(returned[1] - r1, DEPTH + 2, "channel 1 credit pulses");
  endtask

  // channel 1 won last, so channel 0 leads the alternation
  task automatic interleave_both();
    logic [7:0] b0 [$];
    logic [7:0] b1 [$];
    rx_q.delete();
    for (int i = 0; i < DEPTH; i++) begin
      b0.push_back(8'($random(seed)));
      b1.push_back(8'($random(seed)));
    end
    for (int i = 0; i < DEPTH; i++) begin
      ch0_valid = 1'b1;
      ch0_data  = b0[i];
      ch1_valid = 1'b1;
      ch1_data  = b1[i];
      sent[0]++;
      sent[1]++;
      @(negedge clk);
    end
    ch0_valid = 1'b0;
    ch1_valid = 1'b0;
    wait_bytes(2 * DEPTH);
    for (int i = 0; i < DEPTH; i++) begin
      check_value(rx_q[2 * i], b0[i], "interleave channel 0 slot");
      check_value(rx_q[2 * i + 1], b1[i], "interleave channel 1 slot");
    end
    wait_idle();
  endtask

  task automatic contiguous_frames();
    logic [7:0] pat [3];
    pat = '{8'h00, 8'hFF, 8'h55};
    rx_q.delete();
    start_cyc_q.delete();
    for (int i = 0; i < 3; i++) send_byte(0, pat[i]);
    wait_bytes(3);
    for (int i = 0; i < 3; i++) begin
      check_value(rx_q[i], pat[i], "back to back byte");
    end
    // busy drops after the stop bit, next start is sampled one cycle later
    for (int i = 1; i < 3; i++) begin
      check_value(start_cyc_q[i] - start_cyc_q[i-1], FRAME_CYC + 1, "frame spacing");
    end
    wait_idle();
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    ch0_valid = 1'b0;
    ch0_data  = '0;
    ch1_valid = 1'b0;
    ch1_data  = '0;
    cyc       = 0;
    errors    = 0;
    checks    = 0;
    seed      = 55;
    valid_cyc = 0;
    sent      = '{0, 0};
    returned  = '{0, 0};
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    idle_after_reset();
    single_byte_latency();
    credit_refill_ch1();
    interleave_both();
    contiguous_frames();
    errors += dut.u_sva.fail_cnt;  // bound assertion failures
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/uart_tx_hub_sva.sv ====
// uart tx hub assertions
// line, handshake and FIFO fill rules, bound into the hub

`timescale 1ns/1ps
`default_nettype none

`include "uart_macros.svh"

module uart_tx_hub_sva
  import uart_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input logic      tx,
  input logic      busy,
  input logic      start,
  input tx_state_e tx_state,
  input logic      ch0_pop,
  input logic      ch1_pop,
  input logic      ch0_valid,
  input logic      ch1_valid,
  input fifo_ptr_t ch0_wr_ptr,
  input fifo_ptr_t ch0_rd_ptr,
  input fifo_ptr_t ch1_wr_ptr,
  input fifo_ptr_t ch1_rd_ptr
);

  localparam fifo_ptr_t DEPTH = fifo_ptr_t'(`UART_FIFO_DEPTH);

  int fail_cnt = 0;  // failed assertions so far

  a_idle_high: assert property (@(posedge clk) disable iff (!rst_n) !busy |-> tx)
    else begin
      $error("tx low while the transmitter is idle");
      fail_cnt++;
    end

  // the transmitter must be between frames when a start arrives
  a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> tx_state == TX_IDLE)
    else begin
      $error("start issued while a frame is in progress");
      fail_cnt++;
    end

  // a pop takes a stored byte, one FIFO at a time
  a_ch0_pop: assert property (@(posedge clk) disable iff (!rst_n)
    ch0_pop |-> !ch1_pop && ch0_wr_ptr != ch0_rd_ptr)
    else begin
      $error("channel 0 popped while empty or together with channel 1");
      fail_cnt++;
    end
  a_ch1_pop: assert property (@(posedge clk) disable iff (!rst_n)
    ch1_pop |-> ch1_wr_ptr != ch1_rd_ptr)
    else begin
      $error("channel 1 popped while empty");
      fail_cnt++;
    end

  a_ch0_room: assert property (@(posedge clk) disable iff (!rst_n)
    ch0_valid |-> fifo_ptr_t'(ch0_wr_ptr - ch0_rd_ptr) != DEPTH)
    else begin
      $error("channel 0 write into a full FIFO");
      fail_cnt++;
    end
  a_ch1_room: assert property (@(posedge clk) disable iff (!rst_n)
    ch1_valid |-> fifo_ptr_t'(ch1_wr_ptr - ch1_rd_ptr) != DEPTH)
    else begin
      $error("channel 1 write into a full FIFO");
      fail_cnt++;
    end

endmodule

bind uart_tx_hub uart_tx_hub_sva u_sva (
  .clk        (clk),
  .rst_n      (rst_n),
  .tx         (tx),
  .busy       (busy),
  .start      (start),
  .tx_state   (u_tx.state),
  .ch0_pop    (ch0_pop),
  .ch1_pop    (ch1_pop),
  .ch0_valid  (ch0_valid),
  .ch1_valid  (ch1_valid),
  .ch0_wr_ptr (u_fifo0.wr_ptr),
  .ch0_rd_ptr (u_fifo0.rd_ptr),
  .ch1_wr_ptr (u_fifo1.wr_ptr),
  .ch1_rd_ptr (u_fifo1.rd_ptr)
);

`default_nettype wire

// ==== uart_tx_hub.f ====
+incdir+include
hdl/uart_pkg.sv
hdl/uart_tx.sv
hdl/tx_channel_fifo.sv
hdl/tx_arbiter.sv
hdl/uart_tx_hub.sv
test/uart_tx_hub_sva.sv
test/tb_uart_tx_hub.sv
